// ==== verilog/isr_dma_config.svh ====
`ifndef ISR_DMA_CONFIG_SVH
`define ISR_DMA_CONFIG_SVH

// ------------------------------------------------
// Region side
// ------------------------------------------------

// Requesting regions, one TLB miss handler each
`define ISR_N_REGIONS 4
`define ISR_N_REGIONS_BITS 2
`define ISR_PID_BITS 6

// ------------------------------------------------
// Transfer side
// ------------------------------------------------

`define ISR_PADDR_BITS 48
`define ISR_LEN_BITS 28
// Completion tags in flight per direction
`define ISR_N_OUTSTANDING 4

`endif

// ==== verilog/dma_req_pkg.sv ====
`default_nettype none

`include "isr_dma_config.svh"

package dma_req_pkg;

  // Transfer direction
  // Picks the engine whose done closes a move
  typedef enum logic {
    dma_rd,
    dma_wr
  } dma_dir_t;

  // One request towards a single engine
  typedef struct packed {
    logic [`ISR_PADDR_BITS-1:0] paddr;
    logic [`ISR_LEN_BITS-1:0]   len;
    // Completion wanted
    logic                       ctl;
  } dma_req_t;

  // Engine answer, one pulse per ctl request
  typedef struct packed {
    logic done;
  } dma_rsp_t;

endpackage

`default_nettype wire

// ==== verilog/isr_req_pkg.sv ====
`default_nettype none

`include "isr_dma_config.svh"

package isr_req_pkg;

  // ISR page move as raised by a region
  typedef struct packed {
    logic [`ISR_PADDR_BITS-1:0] paddr_host;
    logic [`ISR_PADDR_BITS-1:0] paddr_card;
    logic [`ISR_LEN_BITS-1:0]   len;
    // Region wants a done back
    logic                       ctl;
    logic [`ISR_PID_BITS-1:0]   pid;
  } isr_req_t;

  // Done pulse back to the region
  typedef struct packed {
    logic                     done;
    logic [`ISR_PID_BITS-1:0] pid;
  } isr_rsp_t;

  // Completion queue entry
  // Who gets the done once the engine finishes
  typedef struct packed {
    logic [`ISR_N_REGIONS_BITS-1:0] region;
    logic [`ISR_PID_BITS-1:0]       pid;
  } isr_tag_t;

endpackage

`default_nettype wire

// ==== verilog/isr_done_queue.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "isr_dma_config.svh"

module isr_done_queue
  import isr_req_pkg::*;
(
  input  logic     aclk,
  input  logic     aresetn,
  input  logic     push_valid,
  output logic     push_ready,
  input  isr_tag_t push_tag,
  input  logic     pop,
  output isr_tag_t head_tag
);

  localparam int DEPTH    = `ISR_N_OUTSTANDING;
  localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_BITS = $clog2(DEPTH + 1);

  isr_tag_t            mem [DEPTH];
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] count;
  logic                do_push;
  logic                do_pop;

  // Pointer step with wrap, depth need not be a power of two
  function automatic logic [PTR_BITS-1:0] ptr_next(input logic [PTR_BITS-1:0] p);
    if (p == PTR_BITS'(DEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  // ------------------------------------------------
  // Handshake
  // ------------------------------------------------

  // Full blocks the arbiter from issuing
  assign push_ready = (count != CNT_BITS'(DEPTH));
  assign do_push    = push_valid & push_ready;
  // Pop on empty is dropped
  assign do_pop     = pop & (count != '0);

  // Head read straight from storage, same cycle as done
  assign head_tag = mem[rd_ptr];

  // ------------------------------------------------
  // Storage and pointers
  // ------------------------------------------------

  always_ff @(posedge aclk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_tag;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      // Simultaneous push and pop keeps the count
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/isr_rr_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "isr_dma_config.svh"

module isr_rr_arbiter
  import dma_req_pkg::*;
  import isr_req_pkg::*;
#(
  parameter dma_dir_t DIR = dma_rd
) (
  input  logic                              aclk,
  input  logic                              aresetn,
  // Regions
  input  logic     [`ISR_N_REGIONS-1:0]     region_valid,
  output logic     [`ISR_N_REGIONS-1:0]     region_ready,
  input  isr_req_t [`ISR_N_REGIONS-1:0]     region_req,
  output isr_rsp_t [`ISR_N_REGIONS-1:0]     region_rsp,
  // Engines
  output logic                              host_valid,
  output logic                              card_valid,
  input  logic                              host_ready,
  input  logic                              card_ready,
  output dma_req_t                          host_req,
  output dma_req_t                          card_req,
  input  dma_rsp_t                          host_rsp,
  input  dma_rsp_t                          card_rsp
);

  localparam int N  = `ISR_N_REGIONS;
  localparam int NB = `ISR_N_REGIONS_BITS;

  logic [NB-1:0] rr_ptr;
  logic [NB-1:0] grant;
  logic          grant_found;
  isr_req_t      grant_req;
  logic          engines_ready;
  logic          queue_ready;
  logic          issue;
  logic          done_sel;
  isr_tag_t      push_tag;
  isr_tag_t      head_tag;

  // ------------------------------------------------
  // Grant search
  // ------------------------------------------------

  // First valid region upward from the pointer, wrapping
  always_comb begin
    int idx;
    grant_found = 1'b0;
    grant       = '0;
    for (int i = 0; i < N; i++) begin
      idx = int'(rr_ptr) + i;
      if (idx >= N) begin
        idx = idx - N;
      end
      if (!grant_found && region_valid[idx]) begin
        grant_found = 1'b1;
        grant       = NB'(idx);
      end
    end
  end

  assign grant_req = region_req[grant];

  // Both engines take the request together, or neither does
  assign engines_ready = host_ready & card_ready;
  // Queue space needed even for non-ctl moves
  assign issue = grant_found & engines_ready & queue_ready;

  always_comb begin
    region_ready        = '0;
    region_ready[grant] = issue;
  end

  // ------------------------------------------------
  // Engine split
  // ------------------------------------------------

  assign host_valid = issue;
  assign card_valid = issue;

  // Own address per side, shared len and ctl
  assign host_req = '{paddr: grant_req.paddr_host, len: grant_req.len, ctl: grant_req.ctl};
  assign card_req = '{paddr: grant_req.paddr_card, len: grant_req.len, ctl: grant_req.ctl};

  // Pointer steps once per issue, whoever was granted
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      rr_ptr <= '0;
    end else if (issue) begin
      if (rr_ptr == NB'(N - 1)) begin
        rr_ptr <= '0;
      end else begin
        rr_ptr <= rr_ptr + 1'b1;
      end
    end
  end

  // ------------------------------------------------
  // Completion
  // ------------------------------------------------

  // Engine finishing last closes the move
  generate
    if (DIR == dma_rd) begin : g_rd_done
      // Read lands on the card
      assign done_sel = card_rsp.done;
    end else begin : g_wr_done
      // Write lands on the host
      assign done_sel = host_rsp.done;
    end
  endgenerate

  // Only ctl moves leave a tag behind
  assign push_tag = '{region: grant, pid: grant_req.pid};

  isr_done_queue i_done_queue (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .push_valid (issue & grant_req.ctl),
    .push_ready (queue_ready),
    .push_tag   (push_tag),
    .pop        (done_sel),
    .head_tag   (head_tag)
  );

  // Head tag picks the region, done pulse passes straight through
  always_comb begin
    region_rsp = '0;
    for (int r = 0; r < N; r++) begin
      if (done_sel && (head_tag.region == NB'(r))) begin
        region_rsp[r].done = 1'b1;
        region_rsp[r].pid  = head_tag.pid;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/isr_dma_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "isr_dma_config.svh"

module isr_dma_top
  import dma_req_pkg::*;
  import isr_req_pkg::*;
(
  input  logic                          aclk,
  input  logic                          aresetn,
  // Read regions
  input  logic     [`ISR_N_REGIONS-1:0] rd_region_valid,
  output logic     [`ISR_N_REGIONS-1:0] rd_region_ready,
  input  isr_req_t [`ISR_N_REGIONS-1:0] rd_region_req,
  output isr_rsp_t [`ISR_N_REGIONS-1:0] rd_region_rsp,
  // Write regions
  input  logic     [`ISR_N_REGIONS-1:0] wr_region_valid,
  output logic     [`ISR_N_REGIONS-1:0] wr_region_ready,
  input  isr_req_t [`ISR_N_REGIONS-1:0] wr_region_req,
  output isr_rsp_t [`ISR_N_REGIONS-1:0] wr_region_rsp,
  // Read engines
  output logic                          rd_host_valid,
  input  logic                          rd_host_ready,
  output dma_req_t                      rd_host_req,
  input  dma_rsp_t                      rd_host_rsp,
  output logic                          rd_card_valid,
  input  logic                          rd_card_ready,
  output dma_req_t                      rd_card_req,
  input  dma_rsp_t                      rd_card_rsp,
  // Write engines
  output logic                          wr_host_valid,
  input  logic                          wr_host_ready,
  output dma_req_t                      wr_host_req,
  input  dma_rsp_t                      wr_host_rsp,
  output logic                          wr_card_valid,
  input  logic                          wr_card_ready,
  output dma_req_t                      wr_card_req,
  input  dma_rsp_t                      wr_card_rsp
);

  // ------------------------------------------------
  // Read path, card done closes
  // ------------------------------------------------

  isr_rr_arbiter #(
    .DIR (dma_rd)
  ) i_rd_arb (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .region_valid (rd_region_valid),
    .region_ready (rd_region_ready),
    .region_req   (rd_region_req),
    .region_rsp   (rd_region_rsp),
    .host_valid   (rd_host_valid),
    .card_valid   (rd_card_valid),
    .host_ready   (rd_host_ready),
    .card_ready   (rd_card_ready),
    .host_req     (rd_host_req),
    .card_req     (rd_card_req),
    .host_rsp     (rd_host_rsp),
    .card_rsp     (rd_card_rsp)
  );

  // ------------------------------------------------
  // Write path, host done closes
  // ------------------------------------------------

  isr_rr_arbiter #(
    .DIR (dma_wr)
  ) i_wr_arb (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .region_valid (wr_region_valid),
    .region_ready (wr_region_ready),
    .region_req   (wr_region_req),
    .region_rsp   (wr_region_rsp),
    .host_valid   (wr_host_valid),
    .card_valid   (wr_card_valid),
    .host_ready   (wr_host_ready),
    .card_ready   (wr_card_ready),
    .host_req     (wr_host_req),
    .card_req     (wr_card_req),
    .host_rsp     (wr_host_rsp),
    .card_rsp     (wr_card_rsp)
  );

endmodule

`default_nettype wire

// ==== bench/dma_engine_model.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "isr_dma_config.svh"

module dma_engine_model
  import dma_req_pkg::*;
#(
  parameter int SEED_OFS = 0
) (
  input  logic     aclk,
  input  logic     aresetn,
  input  logic     valid,
  output logic     ready,
  input  dma_req_t req,
  output dma_rsp_t rsp,
  // Withholds done pulses while high
  input  logic     hold_done
);

  int unsigned lcg_state;
  int          cyc;
  // Cycle at which each pending ctl transfer finishes, issue order
  int          due_q[$];

  // Linear congruential step, upper bits returned
  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return (lcg_state >> 16) & 32'h7fff;
  endfunction

  initial begin
    lcg_state = 32'd96480 + SEED_OFS;
    ready <= 1'b0;
    rsp   <= '0;
  end

  // ------------------------------------------------
  // Ready and done behavior
  // ------------------------------------------------

  always @(posedge aclk) begin
    if (!aresetn) begin
      ready    <= 1'b0;
      rsp.done <= 1'b0;
      cyc = 0;
      due_q.delete();
    end else begin
      cyc = cyc + 1;
      // Accepted ctl transfer finishes a few cycles later
      if (valid && ready && req.ctl) begin
        due_q.push_back(cyc + 1 + int'(lcg_next() % 6));
      end
      rsp.done <= 1'b0;
      if (!hold_done && (due_q.size() > 0) && (due_q[0] <= cyc)) begin
        rsp.done <= 1'b1;
        void'(due_q.pop_front());
      end
      // Ready about three cycles in four
      ready <= ((lcg_next() % 4) != 0);
    end
  end

endmodule

`default_nettype wire

// ==== bench/tb_isr_dma.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "isr_dma_config.svh"

module tb_isr_dma
  import dma_req_pkg::*;
  import isr_req_pkg::*;
;

  localparam int N     = `ISR_N_REGIONS;
  localparam int DEPTH = `ISR_N_OUTSTANDING;
  localparam int MAXTR = 64;

  logic aclk;
  logic aresetn;

  // Index 0 is the read path, index 1 the write path
  logic     [N-1:0] valid_v [2];
  logic     [N-1:0] ready_v [2];
  isr_req_t [N-1:0] req_v   [2];
  isr_rsp_t [N-1:0] rsp_v   [2];
  logic             host_v  [2];
  logic             card_v  [2];
  logic             host_rdy [2];
  logic             card_rdy [2];
  dma_req_t         host_req_w [2];
  dma_req_t         card_req_w [2];
  dma_rsp_t         host_rsp_w [2];
  dma_rsp_t         card_rsp_w [2];
  logic             hold_v [2];

  // Trace contents
  isr_req_t tr_req [MAXTR];
  int       tr_sec [MAXTR];
  int       tr_dir [MAXTR];
  int       tr_reg [MAXTR];
  int       trace_len;
  int       ctl_total [2];

  // Driver state
  int cur_sec;
  bit reload;
  int pos [2][N];
  bit accepted [2][N];
  bit running;

  // Reference model state
  int         ref_ptr [2];
  logic [1:0] tq_reg [2][MAXTR];
  logic [5:0] tq_pid [2][MAXTR];
  int         tq_head [2];
  int         tq_tail [2];
  int         issued [2];
  int         dones [2];
  int         errors;
  int         checks;

  isr_dma_top i_dut (
    .aclk            (aclk),
    .aresetn         (aresetn),
    .rd_region_valid (valid_v[0]),
    .rd_region_ready (ready_v[0]),
    .rd_region_req   (req_v[0]),
    .rd_region_rsp   (rsp_v[0]),
    .wr_region_valid (valid_v[1]),
    .wr_region_ready (ready_v[1]),
    .wr_region_req   (req_v[1]),
    .wr_region_rsp   (rsp_v[1]),
    .rd_host_valid   (host_v[0]),
    .rd_host_ready   (host_rdy[0]),
    .rd_host_req     (host_req_w[0]),
    .rd_host_rsp     (host_rsp_w[0]),
    .rd_card_valid   (card_v[0]),
    .rd_card_ready   (card_rdy[0]),
    .rd_card_req     (card_req_w[0]),
    .rd_card_rsp     (card_rsp_w[0]),
    .wr_host_valid   (host_v[1]),
    .wr_host_ready   (host_rdy[1]),
    .wr_host_req     (host_req_w[1]),
    .wr_host_rsp     (host_rsp_w[1]),
    .wr_card_valid   (card_v[1]),
    .wr_card_ready   (card_rdy[1]),
    .wr_card_req     (card_req_w[1]),
    .wr_card_rsp     (card_rsp_w[1])
  );

  // Read closes on card done, write on host done
  dma_engine_model #(.SEED_OFS(0)) i_rd_host (
    .aclk(aclk), .aresetn(aresetn), .valid(host_v[0]), .ready(host_rdy[0]),
    .req(host_req_w[0]), .rsp(host_rsp_w[0]), .hold_done(1'b0)
  );
  dma_engine_model #(.SEED_OFS(1)) i_rd_card (
    .aclk(aclk), .aresetn(aresetn), .valid(card_v[0]), .ready(card_rdy[0]),
    .req(card_req_w[0]), .rsp(card_rsp_w[0]), .hold_done(hold_v[0])
  );
  dma_engine_model #(.SEED_OFS(2)) i_wr_host (
    .aclk(aclk), .aresetn(aresetn), .valid(host_v[1]), .ready(host_rdy[1]),
    .req(host_req_w[1]), .rsp(host_rsp_w[1]), .hold_done(hold_v[1])
  );
  dma_engine_model #(.SEED_OFS(3)) i_wr_card (
    .aclk(aclk), .aresetn(aresetn), .valid(card_v[1]), .ready(card_rdy[1]),
    .req(card_req_w[1]), .rsp(card_rsp_w[1]), .hold_done(1'b0)
  );

  initial begin
    aclk = 1'b0;
    forever #5 aclk = ~aclk;
  end

  task automatic report_value(input string name, input logic [63:0] exp_val,
                              input logic [63:0] act_val);
    $display("[FAIL] %0t %s expected %0h actual %0h", $time, name, exp_val, act_val);
    errors++;
  endtask

  task automatic report_text(input string msg);
    $display("Error at %0t: %s", $time, msg);
    errors++;
  endtask

  // Next trace entry for a region and direction in the active section
  function automatic int find_next(input int d, input int r, input int from);
    for (int i = from; i < trace_len; i++) begin
      if (tr_sec[i] == cur_sec && tr_dir[i] == d && tr_reg[i] == r) begin
        return i;
      end
    end
    return -1;
  endfunction

  function automatic bit all_idle();
    for (int d = 0; d < 2; d++) begin
      if (tq_head[d] != tq_tail[d]) begin
        return 1'b0;
      end
      for (int r = 0; r < N; r++) begin
        if (pos[d][r] >= 0) begin
          return 1'b0;
        end
      end
    end
    return 1'b1;
  endfunction

  task automatic load_trace();
    int       fd;
    int       sec;
    int       dir;
    int       rg;
    int       ctl;
    logic [47:0] ph;
    logic [47:0] pc;
    logic [27:0] ln;
    logic [5:0]  pid;
    string    line;
    fd = $fopen("bench/isr_dma_trace.txt", "r");
    if (fd == 0) begin
      report_text("trace file could not be opened");
      return;
    end
    while (!$feof(fd) && trace_len < MAXTR) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 2 && line[0] != "#") begin
        if ($sscanf(line, "%d %d %d %h %h %h %d %h", sec, dir, rg, ph, pc, ln, ctl,
                    pid) == 8) begin
          tr_sec[trace_len] = sec;
          tr_dir[trace_len] = dir;
          tr_reg[trace_len] = rg;
          tr_req[trace_len] = '{paddr_host: ph, paddr_card: pc, len: ln,
                                ctl: ctl[0], pid: pid};
          if (ctl != 0) begin
            ctl_total[dir]++;
          end
          trace_len++;
        end
      end
    end
    $fclose(fd);
  endtask

  // ------------------------------------------------
  // Region drivers, rising edge
  // ------------------------------------------------

  always @(posedge aclk) begin
    for (int d = 0; d < 2; d++) begin
      for (int r = 0; r < N; r++) begin
        if (reload) begin
          pos[d][r] = find_next(d, r, 0);
        end else if (accepted[d][r]) begin
          accepted[d][r] = 1'b0;
          pos[d][r] = find_next(d, r, pos[d][r] + 1);
        end
        if (pos[d][r] >= 0) begin
          valid_v[d][r] <= 1'b1;
          req_v[d][r]   <= tr_req[pos[d][r]];
        end else begin
          valid_v[d][r] <= 1'b0;
        end
      end
    end
    reload = 1'b0;
  end

  // ------------------------------------------------
  // Reference model and checks, falling edge
  // ------------------------------------------------

  always @(negedge aclk) begin : check_proc
    int         g;
    int         idx;
    int         i;
    logic       exp_issue;
    logic       sel_done;
    logic [N-1:0] vv;
    logic [1:0] er;
    if (aresetn && running) begin
      for (int d = 0; d < 2; d++) begin
        vv = valid_v[d];
        checks++;
        if (host_v[d] !== card_v[d]) begin
          report_value("card_valid", host_v[d], card_v[d]);
        end
        exp_issue = (|vv) && host_rdy[d] && card_rdy[d] &&
                    ((tq_tail[d] - tq_head[d]) < DEPTH);
        if (host_v[d] !== exp_issue) begin
          report_value("host_valid", exp_issue, host_v[d]);
        end
        if (exp_issue) begin
          g = -1;
          for (int k = 0; k < N; k++) begin
            idx = (ref_ptr[d] + k) % N;
            if (g < 0 && vv[idx]) begin
              g = idx;
            end
          end
          if (ready_v[d] !== (N'(1) << g)) begin
            report_value("region_ready", N'(1) << g, ready_v[d]);
          end
          i = pos[d][g];
          if (host_req_w[d].paddr !== tr_req[i].paddr_host) begin
            report_value("host_req.paddr", tr_req[i].paddr_host, host_req_w[d].paddr);
          end
          if (card_req_w[d].paddr !== tr_req[i].paddr_card) begin
            report_value("card_req.paddr", tr_req[i].paddr_card, card_req_w[d].paddr);
          end
          if (host_req_w[d].len !== tr_req[i].len) begin
            report_value("host_req.len", tr_req[i].len, host_req_w[d].len);
          end
          if (card_req_w[d].len !== tr_req[i].len) begin
            report_value("card_req.len", tr_req[i].len, card_req_w[d].len);
          end
          if (host_req_w[d].ctl !== tr_req[i].ctl) begin
            report_value("host_req.ctl", tr_req[i].ctl, host_req_w[d].ctl);
          end
          if (card_req_w[d].ctl !== tr_req[i].ctl) begin
            report_value("card_req.ctl", tr_req[i].ctl, card_req_w[d].ctl);
          end
          if (tr_req[i].ctl) begin
            tq_reg[d][tq_tail[d]] = 2'(g);
            tq_pid[d][tq_tail[d]] = tr_req[i].pid;
            tq_tail[d]++;
          end
          ref_ptr[d] = (ref_ptr[d] + 1) % N;
          accepted[d][g] = 1'b1;
          issued[d]++;
        end else if (ready_v[d] !== '0) begin
          report_value("region_ready", 0, ready_v[d]);
        end
        // Completion routing from the closing engine only
        sel_done = (d == 0) ? card_rsp_w[0].done : host_rsp_w[1].done;
        if (sel_done) begin
          if (tq_head[d] == tq_tail[d]) begin
            report_text("engine done arrived with no ctl transfer outstanding");
          end else begin
            er = tq_reg[d][tq_head[d]];
            for (int r = 0; r < N; r++) begin
              if (rsp_v[d][r].done !== (r == er)) begin
                report_value("region_rsp.done", (r == er), rsp_v[d][r].done);
              end
            end
            if (rsp_v[d][er].pid !== tq_pid[d][tq_head[d]]) begin
              report_value("region_rsp.pid", tq_pid[d][tq_head[d]], rsp_v[d][er].pid);
            end
            tq_head[d]++;
            dones[d]++;
          end
        end else begin
          for (int r = 0; r < N; r++) begin
            if (rsp_v[d][r].done !== 1'b0) begin
              report_value("region_rsp.done", 0, rsp_v[d][r].done);
            end
          end
        end
      end
    end
  end

  // Run length bound from the trace size
  // Trace is loaded before the first edge
  initial begin
    @(posedge aclk);
    repeat (trace_len * 200) @(posedge aclk);
    $display("Timeout: the run did not complete in %0d cycles", trace_len * 200);
    $display("Done: errors found");
    $finish;
  end

  // ------------------------------------------------
  // Main sequence
  // ------------------------------------------------

  initial begin
    int base [2];
    aresetn <= 1'b0;
    valid_v[0] <= '0;
    valid_v[1] <= '0;
    req_v[0] <= '0;
    req_v[1] <= '0;
    hold_v[0] = 1'b0;
    hold_v[1] = 1'b0;
    for (int d = 0; d < 2; d++) begin
      for (int r = 0; r < N; r++) begin
        pos[d][r] = -1;
        accepted[d][r] = 1'b0;
      end
    end
    load_trace();
    repeat (10) @(posedge aclk);
    aresetn <= 1'b1;
    @(negedge aclk);
    running = 1'b1;
    // Normal traffic, random engine ready and latency
    cur_sec = 0;
    reload = 1'b1;
    @(negedge aclk);
    while (!all_idle()) @(negedge aclk);
    // Back-pressure: closing engines hold their done
    hold_v[0] = 1'b1;
    hold_v[1] = 1'b1;
    base[0] = issued[0];
    base[1] = issued[1];
    cur_sec = 1;
    reload = 1'b1;
    @(negedge aclk);
    while ((tq_tail[0] - tq_head[0]) < DEPTH || (tq_tail[1] - tq_head[1]) < DEPTH) begin
      @(negedge aclk);
    end
    repeat (30) @(negedge aclk);
    for (int d = 0; d < 2; d++) begin
      if (issued[d] - base[d] != DEPTH) begin
        report_value("issued_while_full", DEPTH, issued[d] - base[d]);
      end
    end
    hold_v[0] = 1'b0;
    hold_v[1] = 1'b0;
    while (!all_idle()) @(negedge aclk);
    repeat (20) @(negedge aclk);
    for (int d = 0; d < 2; d++) begin
      if (dones[d] != ctl_total[d]) begin
        report_value("done_count", ctl_total[d], dones[d]);
      end
    end
    $display("Summary: checks %0d, rd issued %0d done %0d, wr issued %0d done %0d, errors %0d",
             checks, issued[0], dones[0], issued[1], dones[1], errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+verilog
verilog/dma_req_pkg.sv
verilog/isr_req_pkg.sv
verilog/isr_done_queue.sv
verilog/isr_rr_arbiter.sv
verilog/isr_dma_top.sv
bench/dma_engine_model.sv
bench/tb_isr_dma.sv

// ==== bench/isr_dma_trace.txt ====
# section(0 normal, 1 back-pressure) dir(0 rd, 1 wr) region paddr_host paddr_card len ctl pid
# Engine requests must carry these fields, dones return the pid to the region
0 0 0 000010000000 0000a0000000 0001000 1 01
0 0 1 000010001000 0000a0001000 0000800 0 02
0 0 2 000010002000 0000a0002000 0002000 1 03
0 0 3 000010003000 0000a0003000 0000400 1 04
0 0 0 000010004000 0000a0004000 0001000 0 05
0 0 0 000010005000 0000a0005000 0001000 1 06
0 0 1 000010006000 0000a0006000 0000200 1 07
0 0 2 000010007000 0000a0007000 0003000 0 08
0 0 3 000010008000 0000a0008000 0001000 1 09
0 0 1 000010009000 0000a0009000 0000100 1 0a
0 0 2 00001000a000 0000a000a000 0001000 1 0b
0 0 0 00001000b000 0000a000b000 0004000 1 0c
0 1 0 000020000000 0000b0000000 0001000 1 11
0 1 0 000020001000 0000b0001000 0000800 1 12
0 1 1 000020002000 0000b0002000 0002000 0 13
0 1 2 000020003000 0000b0003000 0000400 1 14
0 1 3 000020004000 0000b0004000 0001000 1 15
0 1 3 000020005000 0000b0005000 0001000 0 16
0 1 1 000020006000 0000b0006000 0000200 1 17
0 1 2 000020007000 0000b0007000 0003000 1 18
0 1 0 000020008000 0000b0008000 0001000 0 19
0 1 3 000020009000 0000b0009000 0000100 1 1a
0 1 1 00002000a000 0000b000a000 0001000 1 1b
0 1 2 00002000b000 0000b000b000 0004000 1 1c
1 0 0 000030000000 0000c0000000 0001000 1 21
1 0 1 000030001000 0000c0001000 0001000 1 22
1 0 2 000030002000 0000c0002000 0001000 1 23
1 0 3 000030003000 0000c0003000 0001000 1 24
1 0 0 000030004000 0000c0004000 0001000 1 25
1 0 1 000030005000 0000c0005000 0001000 1 26
1 1 0 000040000000 0000d0000000 0002000 1 31
1 1 1 000040001000 0000d0001000 0002000 1 32
1 1 2 000040002000 0000d0002000 0002000 1 33
1 1 3 000040003000 0000d0003000 0002000 1 34
1 1 2 000040004000 0000d0004000 0002000 1 35
1 1 3 000040005000 0000d0005000 0002000 1 36
